//--- hdl/dma_legalizer_config.svh
`ifndef DMA_LEGALIZER_CONFIG_SVH
`define DMA_LEGALIZER_CONFIG_SVH

// ------------------------------------------------------------
// Bus and transfer geometry
// ------------------------------------------------------------

// Data bus width in bits
`define DMA_DATA_WIDTH 32

// Byte address width on both sides
`define DMA_ADDR_WIDTH 24

// Width of the transfer length in bytes
`define DMA_LEN_WIDTH 16

// Hard cap on the page size in bytes
// AXI forbids bursts crossing a 4 KiB boundary
`define DMA_PAGE_MAX 4096

`endif

//--- hdl/dma_xfer_pkg.sv
`default_nettype none

`include "dma_legalizer_config.svh"

package dma_xfer_pkg;

    // ------------------------------------------------------------
    // Derived geometry
    // ------------------------------------------------------------
    // Bytes per bus word
    localparam int unsigned STRB_WIDTH      = `DMA_DATA_WIDTH / 8;
    // Bits addressing a byte inside one word
    localparam int unsigned OFFSET_WIDTH    = $clog2(STRB_WIDTH);
    // 256 beats at most, never above the protocol cap
    localparam int unsigned PAGE_SIZE       = (256 * STRB_WIDTH > `DMA_PAGE_MAX) ?
                                              `DMA_PAGE_MAX : 256 * STRB_WIDTH;
    localparam int unsigned PAGE_ADDR_WIDTH = $clog2(PAGE_SIZE);

    // Source or destination protocol
    typedef enum logic {
        AXI = 1'b0,
        OBI = 1'b1
    } protocol_e;

    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DMA_LEN_WIDTH-1:0]  len_t;
    // One extra bit so a full page still fits
    typedef logic [PAGE_ADDR_WIDTH:0]   page_len_t;
    typedef logic [OFFSET_WIDTH-1:0]    offset_t;

    // Options of one side, held for the whole transfer
    typedef struct packed {
        protocol_e  protocol;
        logic       reduce_len;
        logic [2:0] max_llen;
    } side_opt_t;

    // Remaining part of the transfer on one side
    typedef struct packed {
        addr_t addr;
        len_t  length;
        logic  valid;
    } side_state_t;

endpackage

`default_nettype wire

//--- hdl/dma_burst_pkg.sv
`default_nettype none

package dma_burst_pkg;

    import dma_xfer_pkg::*;

    // ------------------------------------------------------------
    // Emitted burst description
    // ------------------------------------------------------------

    // Number of beats minus one, AXI len encoding
    typedef logic [7:0] beats_t;

    // One legalized read or write burst
    typedef struct packed {
        // Word aligned start address
        addr_t     addr;
        // Payload bytes in this burst
        page_len_t num_bytes;
        beats_t    beats;
        // First valid byte in the first beat
        offset_t   offset;
        // End of valid bytes in the last beat, mod word
        offset_t   tailer;
        // Datapath realignment amount
        offset_t   shift;
        // Final burst of the transfer, write side only
        logic      last;
    } burst_t;

endpackage

`default_nettype wire

//--- hdl/dma_side_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dma_side_if import dma_xfer_pkg::*, dma_burst_pkg::*; ();

    // ------------------------------------------------------------
    // Control to tracker
    // ------------------------------------------------------------
    logic      load;
    addr_t     load_addr;
    len_t      load_len;
    side_opt_t opt;
    // Take one burst this cycle
    logic      advance;
    // Abort and drop the stored transfer
    logic      clear;
    // Burst size granted by the coupling logic
    page_len_t bytes_possible;

    // ------------------------------------------------------------
    // Tracker to control
    // ------------------------------------------------------------
    // Own distance to the next boundary
    page_len_t bytes_to_pb;
    logic      done;
    logic      busy;
    burst_t    burst;

    modport ctrl (
        output load, load_addr, load_len, opt, advance, clear, bytes_possible,
        input  bytes_to_pb, done, busy
    );

    modport side (
        input  load, load_addr, load_len, opt, advance, clear, bytes_possible,
        output bytes_to_pb, done, busy, burst
    );

endinterface

`default_nettype wire

//--- hdl/dma_page_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module dma_page_splitter import dma_xfer_pkg::*; (
    input  addr_t     addr_i,
    input  side_opt_t opt_i,
    output page_len_t bytes_to_pb_o
);

    // Active boundary size in bytes, always a power of two
    page_len_t bound_size;
    // Burst length limit from max_llen
    page_len_t reduced_size;
    // Position of addr inside the current boundary window
    page_len_t addr_in_bound;

    // ------------------------------------------------------------
    // Boundary size
    // ------------------------------------------------------------
    always_comb begin
        // 2^max_llen beats of one word each
        reduced_size = page_len_t'(STRB_WIDTH) << opt_i.max_llen;
        bound_size   = page_len_t'(PAGE_SIZE);
        // Only tighten, never widen past the page
        if (opt_i.reduce_len && (reduced_size < bound_size)) begin
            bound_size = reduced_size;
        end
    end

    // ------------------------------------------------------------
    // Distance to boundary
    // ------------------------------------------------------------
    always_comb begin
        // Low address bits are enough, window is at most one page
        addr_in_bound = page_len_t'(addr_i) & (bound_size - page_len_t'(1));
        // Aligned address yields a full window
        bytes_to_pb_o = bound_size - addr_in_bound;
    end

endmodule

`default_nettype wire

//--- hdl/dma_side_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module dma_side_tracker import dma_xfer_pkg::*, dma_burst_pkg::*; #(
    // Write side negates the shift and flags the last burst
    parameter bit IS_WRITE = 1'b0
) (
    input  logic clk_i,
    input  logic rst_n_i,
    dma_side_if.side side
);

    side_state_t state_q;
    side_state_t state_d;

    // Remaining length fits into the granted burst
    logic        fits;
    // Bytes of the burst currently presented
    page_len_t   num_bytes;
    offset_t     addr_offset;
    // Burst end position, relative to first word
    page_len_t   end_pos;

    // ------------------------------------------------------------
    // Boundary distance
    // ------------------------------------------------------------
    dma_page_splitter u_page_splitter (
        .addr_i        ( state_q.addr     ),
        .opt_i         ( side.opt         ),
        .bytes_to_pb_o ( side.bytes_to_pb )
    );

    // ------------------------------------------------------------
    // Burst sizing
    // ------------------------------------------------------------
    assign fits        = state_q.length <= len_t'(side.bytes_possible);
    assign num_bytes   = fits ? page_len_t'(state_q.length) : side.bytes_possible;
    assign addr_offset = state_q.addr[OFFSET_WIDTH-1:0];
    assign end_pos     = num_bytes + page_len_t'(addr_offset);

    // Idle side never holds up a new request
    assign side.done = fits | ~state_q.valid;
    assign side.busy = state_q.valid;

    always_comb begin
        state_d = state_q;
        // Kill first, a same cycle load still wins
        if (side.clear) begin
            state_d = '0;
        end
        if (side.load) begin
            state_d = '{addr: side.load_addr, length: side.load_len, valid: 1'b1};
        end else if (side.advance && state_q.valid) begin
            if (fits) begin
                state_d.valid = 1'b0;
            end else begin
                state_d.addr   = state_q.addr + addr_t'(num_bytes);
                state_d.length = state_q.length - len_t'(num_bytes);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= '0;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------
    // Burst formatting
    // ------------------------------------------------------------
    always_comb begin
        side.burst.addr      = state_q.addr & ~addr_t'(STRB_WIDTH - 1);
        side.burst.num_bytes = num_bytes;
        // AXI len, bounded to 255 by the page rule
        side.burst.beats     = beats_t'((end_pos - page_len_t'(1)) >> OFFSET_WIDTH);
        // OBI moves single words only
        if (side.opt.protocol == OBI) begin
            side.burst.beats = '0;
        end
        side.burst.offset    = addr_offset;
        side.burst.tailer    = offset_t'(end_pos);
        side.burst.shift     = IS_WRITE ? offset_t'(-addr_offset) : addr_offset;
        side.burst.last      = IS_WRITE ? fits : 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/dma_legalizer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dma_legalizer_ctrl import dma_xfer_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Request channel
    input  logic       req_valid_i,
    input  len_t       req_length_i,
    input  addr_t      req_src_addr_i,
    input  addr_t      req_dst_addr_i,
    input  protocol_e  req_src_protocol_i,
    input  protocol_e  req_dst_protocol_i,
    input  logic       req_decouple_rw_i,
    input  logic       req_src_reduce_len_i,
    input  logic [2:0] req_src_max_llen_i,
    input  logic       req_dst_reduce_len_i,
    input  logic [2:0] req_dst_max_llen_i,
    output logic       req_ready_o,

    input  logic       r_ready_i,
    input  logic       w_ready_i,
    input  logic       flush_i,
    input  logic       kill_i,

    output logic       r_valid_o,
    output logic       w_valid_o,

    dma_side_if.ctrl   rd,
    dma_side_if.ctrl   wr
);

    side_opt_t src_opt_q;
    side_opt_t dst_opt_q;
    logic      decouple_rw_q;

    logic      decoupled;
    logic      accept;
    page_len_t c_bytes_to_pb;

    // ------------------------------------------------------------
    // Options, latched with the transfer
    // ------------------------------------------------------------
    assign accept = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            src_opt_q     <= '0;
            dst_opt_q     <= '0;
            decouple_rw_q <= 1'b0;
        end else if (accept) begin
            src_opt_q     <= '{req_src_protocol_i, req_src_reduce_len_i, req_src_max_llen_i};
            dst_opt_q     <= '{req_dst_protocol_i, req_dst_reduce_len_i, req_dst_max_llen_i};
            decouple_rw_q <= req_decouple_rw_i;
        end
    end

    assign rd.opt = src_opt_q;
    assign wr.opt = dst_opt_q;

    // OBI has no bursts to pair up, so it always runs on its own
    assign decoupled = decouple_rw_q | (src_opt_q.protocol == OBI) |
                       (dst_opt_q.protocol == OBI);

    // ------------------------------------------------------------
    // Coupling, nearer boundary wins
    // ------------------------------------------------------------
    assign c_bytes_to_pb = (rd.bytes_to_pb < wr.bytes_to_pb) ? rd.bytes_to_pb :
                                                               wr.bytes_to_pb;
    assign rd.bytes_possible = decoupled ? rd.bytes_to_pb : c_bytes_to_pb;
    assign wr.bytes_possible = decoupled ? wr.bytes_to_pb : c_bytes_to_pb;

    // ------------------------------------------------------------
    // Flow control
    // ------------------------------------------------------------
    always_comb begin
        if (decoupled) begin
            rd.advance = r_ready_i & ~flush_i;
            wr.advance = w_ready_i & ~flush_i;
        end else begin
            // Lockstep, one stalled side holds both
            rd.advance = r_ready_i & w_ready_i & ~flush_i;
            wr.advance = r_ready_i & w_ready_i & ~flush_i;
        end
        r_valid_o = rd.busy & rd.advance;
        w_valid_o = wr.busy & wr.advance;
    end

    // Next request only once both final bursts can leave
    assign req_ready_o = rd.done & wr.done & r_ready_i & w_ready_i & ~flush_i;

    assign rd.load      = accept;
    assign rd.load_addr = req_src_addr_i;
    assign rd.load_len  = req_length_i;
    assign wr.load      = accept;
    assign wr.load_addr = req_dst_addr_i;
    assign wr.load_len  = req_length_i;

    assign rd.clear = kill_i;
    assign wr.clear = kill_i;

endmodule

`default_nettype wire

//--- hdl/dma_legalizer.sv
`timescale 1ns/1ps
`default_nettype none

module dma_legalizer import dma_xfer_pkg::*, dma_burst_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,

    // ------------------------------------------------------------
    // Request channel
    // ------------------------------------------------------------
    input  logic       req_valid_i,
    input  len_t       req_length_i,
    input  addr_t      req_src_addr_i,
    input  addr_t      req_dst_addr_i,
    input  protocol_e  req_src_protocol_i,
    input  protocol_e  req_dst_protocol_i,
    input  logic       req_decouple_rw_i,
    input  logic       req_src_reduce_len_i,
    input  logic [2:0] req_src_max_llen_i,
    input  logic       req_dst_reduce_len_i,
    input  logic [2:0] req_dst_max_llen_i,
    output logic       req_ready_o,

    // Read bursts
    output logic       r_valid_o,
    output addr_t      r_addr_o,
    output page_len_t  r_bytes_o,
    output beats_t     r_beats_o,
    output offset_t    r_offset_o,
    output offset_t    r_tailer_o,
    output offset_t    r_shift_o,
    input  logic       r_ready_i,

    // Write bursts
    output logic       w_valid_o,
    output addr_t      w_addr_o,
    output page_len_t  w_bytes_o,
    output beats_t     w_beats_o,
    output offset_t    w_offset_o,
    output offset_t    w_tailer_o,
    output offset_t    w_shift_o,
    output logic       w_last_o,
    input  logic       w_ready_i,

    input  logic       flush_i,
    input  logic       kill_i,
    output logic       r_busy_o,
    output logic       w_busy_o
);

    dma_side_if rd_if ();
    dma_side_if wr_if ();

    dma_legalizer_ctrl u_ctrl (
        .clk_i                ( clk_i                ),
        .rst_n_i              ( rst_n_i              ),
        .req_valid_i          ( req_valid_i          ),
        .req_length_i         ( req_length_i         ),
        .req_src_addr_i       ( req_src_addr_i       ),
        .req_dst_addr_i       ( req_dst_addr_i       ),
        .req_src_protocol_i   ( req_src_protocol_i   ),
        .req_dst_protocol_i   ( req_dst_protocol_i   ),
        .req_decouple_rw_i    ( req_decouple_rw_i    ),
        .req_src_reduce_len_i ( req_src_reduce_len_i ),
        .req_src_max_llen_i   ( req_src_max_llen_i   ),
        .req_dst_reduce_len_i ( req_dst_reduce_len_i ),
        .req_dst_max_llen_i   ( req_dst_max_llen_i   ),
        .req_ready_o          ( req_ready_o          ),
        .r_ready_i            ( r_ready_i            ),
        .w_ready_i            ( w_ready_i            ),
        .flush_i              ( flush_i              ),
        .kill_i               ( kill_i               ),
        .r_valid_o            ( r_valid_o            ),
        .w_valid_o            ( w_valid_o            ),
        .rd                   ( rd_if.ctrl           ),
        .wr                   ( wr_if.ctrl           )
    );

    dma_side_tracker #(.IS_WRITE(1'b0)) u_rd_side (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .side    ( rd_if.side )
    );

    dma_side_tracker #(.IS_WRITE(1'b1)) u_wr_side (
        .clk_i   ( clk_i      ),
        .rst_n_i ( rst_n_i    ),
        .side    ( wr_if.side )
    );

    // Burst fields onto the flat ports
    assign r_addr_o   = rd_if.burst.addr;
    assign r_bytes_o  = rd_if.burst.num_bytes;
    assign r_beats_o  = rd_if.burst.beats;
    assign r_offset_o = rd_if.burst.offset;
    assign r_tailer_o = rd_if.burst.tailer;
    assign r_shift_o  = rd_if.burst.shift;
    assign r_busy_o   = rd_if.busy;

    assign w_addr_o   = wr_if.burst.addr;
    assign w_bytes_o  = wr_if.burst.num_bytes;
    assign w_beats_o  = wr_if.burst.beats;
    assign w_offset_o = wr_if.burst.offset;
    assign w_tailer_o = wr_if.burst.tailer;
    assign w_shift_o  = wr_if.burst.shift;
    assign w_last_o   = wr_if.burst.last;
    assign w_busy_o   = wr_if.busy;

endmodule

`default_nettype wire

//--- verif/dma_legalizer_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module dma_legalizer_assertions import dma_xfer_pkg::*, dma_burst_pkg::*; (
    input logic      clk_i,
    input logic      rst_n_i,
    input logic      flush_i,
    input logic      r_valid_o,
    input logic      w_valid_o,
    input logic      r_busy_o,
    input logic      w_busy_o,
    input page_len_t r_bytes_o,
    input page_len_t w_bytes_o,
    input beats_t    r_beats_o,
    input beats_t    w_beats_o,
    input addr_t     r_addr_o,
    input addr_t     w_addr_o
);

    // ------------------------------------------------------------
    // Emission gating
    // ------------------------------------------------------------
    a_no_valid_in_flush: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        flush_i |-> (!r_valid_o && !w_valid_o))
        else $error("burst valid while flush is high");

    a_valid_needs_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!r_valid_o || r_busy_o) && (!w_valid_o || w_busy_o))
        else $error("burst valid on an idle side");

    // Empty bursts never leave the legalizer
    a_bytes_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!r_valid_o || (r_bytes_o != '0)) && (!w_valid_o || (w_bytes_o != '0)))
        else $error("burst with zero bytes");

    // ------------------------------------------------------------
    // Page rule, 1 KiB pages of 4 byte words
    // ------------------------------------------------------------
    a_beats_in_page: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!r_valid_o || (32'(r_addr_o[9:0]) + (32'(r_beats_o) + 1) * 4 <= 1024)) &&
        (!w_valid_o || (32'(w_addr_o[9:0]) + (32'(w_beats_o) + 1) * 4 <= 1024)))
        else $error("burst crosses a page boundary");

endmodule

bind dma_legalizer dma_legalizer_assertions u_assertions (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .flush_i   ( flush_i   ),
    .r_valid_o ( r_valid_o ),
    .w_valid_o ( w_valid_o ),
    .r_busy_o  ( r_busy_o  ),
    .w_busy_o  ( w_busy_o  ),
    .r_bytes_o ( r_bytes_o ),
    .w_bytes_o ( w_bytes_o ),
    .r_beats_o ( r_beats_o ),
    .w_beats_o ( w_beats_o ),
    .r_addr_o  ( r_addr_o  ),
    .w_addr_o  ( w_addr_o  )
);

`default_nettype wire

//--- verif/tb_dma_legalizer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_legalizer import dma_xfer_pkg::*, dma_burst_pkg::*;;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int PAGE_BYTES     = 1024;

    // Expected burst with the same fields as the ports
    typedef struct packed {
        logic [23:0] addr;
        logic [10:0] bytes;
        logic [7:0]  beats;
        logic [1:0]  offset;
        logic [1:0]  tailer;
        logic [1:0]  shift;
        logic        last;
    } burst_s;

    logic       clk_i;
    logic       rst_n_i;
    logic       req_valid_i;
    len_t       req_length_i;
    addr_t      req_src_addr_i;
    addr_t      req_dst_addr_i;
    protocol_e  req_src_protocol_i;
    protocol_e  req_dst_protocol_i;
    logic       req_decouple_rw_i;
    logic       req_src_reduce_len_i;
    logic [2:0] req_src_max_llen_i;
    logic       req_dst_reduce_len_i;
    logic [2:0] req_dst_max_llen_i;
    logic       req_ready_o;
    logic       r_valid_o;
    addr_t      r_addr_o;
    page_len_t  r_bytes_o;
    beats_t     r_beats_o;
    offset_t    r_offset_o;
    offset_t    r_tailer_o;
    offset_t    r_shift_o;
    logic       r_ready_i;
    logic       w_valid_o;
    addr_t      w_addr_o;
    page_len_t  w_bytes_o;
    beats_t     w_beats_o;
    offset_t    w_offset_o;
    offset_t    w_tailer_o;
    offset_t    w_shift_o;
    logic       w_last_o;
    logic       w_ready_i;
    logic       flush_i;
    logic       kill_i;
    logic       r_busy_o;
    logic       w_busy_o;

    burst_s exp_r[$];
    burst_s exp_w[$];
    logic   coupled;
    int     errors;
    int     tests_run;
    int     tests_failed;

    dma_legalizer u_dut (.*);

    // ------------------------------------------------------------
    // Clock
    // ------------------------------------------------------------
    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // Boundary window of one side
    function automatic int unsigned bound_of(logic red, logic [2:0] llen);
        int unsigned b;
        b = PAGE_BYTES;
        if (red && ((4 << llen) < b)) begin
            b = 4 << llen;
        end
        return b;
    endfunction

    function automatic int unsigned dist_to(int unsigned addr, int unsigned b);
        return b - (addr % b);
    endfunction

    function automatic burst_s make_burst(int unsigned addr, int unsigned n, bit obi,
                                          bit wr, bit fin);
        burst_s      b;
        int unsigned off;
        off      = addr % 4;
        b.addr   = 24'(addr & 32'hffff_fffc);
        b.bytes  = 11'(n);
        b.beats  = obi ? 8'd0 : 8'((n + off - 1) / 4);
        b.offset = 2'(off);
        b.tailer = 2'((n + off) % 4);
        // Write side realigns the other way
        b.shift  = wr ? 2'((4 - off) % 4) : 2'(off);
        b.last   = wr && fin;
        return b;
    endfunction

    task automatic build_model(int unsigned src, int unsigned dst, int unsigned len,
                               bit sobi, bit dobi, bit dec, int unsigned sb,
                               int unsigned db);
        int unsigned ra;
        int unsigned wa;
        int unsigned rl;
        int unsigned wl;
        int unsigned n;
        ra = src;
        wa = dst;
        rl = len;
        wl = len;
        exp_r.delete();
        exp_w.delete();
        coupled = !(dec || sobi || dobi);
        if (coupled) begin
            while (rl > 0) begin
                n = dist_to(ra, sb) < dist_to(wa, db) ? dist_to(ra, sb) : dist_to(wa, db);
                if (rl < n) n = rl;
                exp_r.push_back(make_burst(ra, n, sobi, 1'b0, 1'b0));
                exp_w.push_back(make_burst(wa, n, dobi, 1'b1, rl == n));
                ra = (ra + n) & 32'hff_ffff;
                wa = (wa + n) & 32'hff_ffff;
                rl -= n;
            end
        end else begin
            while (rl > 0) begin
                n = (rl < dist_to(ra, sb)) ? rl : dist_to(ra, sb);
                exp_r.push_back(make_burst(ra, n, sobi, 1'b0, 1'b0));
                ra = (ra + n) & 32'hff_ffff;
                rl -= n;
            end
            while (wl > 0) begin
                n = (wl < dist_to(wa, db)) ? wl : dist_to(wa, db);
                exp_w.push_back(make_burst(wa, n, dobi, 1'b1, wl == n));
                wa = (wa + n) & 32'hff_ffff;
                wl -= n;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Reporting
    // ------------------------------------------------------------
    task automatic report_mismatch(string name, burst_s exp, burst_s act);
        $display("ERR %s expected %h actual %h", name, exp, act);
        errors++;
    endtask

    task automatic report_problem(string name, string what);
        $display("%s: %s", name, what);
        errors++;
    endtask

    task automatic abort_on_timeout(string name, string what);
        $display("%s: timed out waiting for %s", name, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    task automatic send_request(string name);
        int cyc;
        cyc = 0;
        @(negedge clk_i);
        req_valid_i = 1'b1;
        r_ready_i   = 1'b1;
        w_ready_i   = 1'b1;
        flush_i     = 1'b0;
        #1;
        while (!req_ready_o) begin
            @(negedge clk_i);
            #1;
            cyc++;
            if (cyc > TIMEOUT_CYCLES) abort_on_timeout(name, "request ready");
        end
        // Taken on the coming rising edge
        @(posedge clk_i);
    endtask

    task automatic check_side(string name, logic valid, burst_s act, ref burst_s q[$]);
        if (valid) begin
            if (q.size() == 0) begin
                report_problem(name, "burst seen after the model list ran out");
            end else if (q[0] != act) begin
                report_mismatch(name, q[0], act);
                void'(q.pop_front());
            end else begin
                void'(q.pop_front());
            end
        end
    endtask

    task automatic collect_bursts(string name, int flush_at, int kill_at);
        int     cyc;
        logic   in_flush;
        burst_s act;
        cyc = 0;
        while ((exp_r.size() > 0) || (exp_w.size() > 0) || r_busy_o || w_busy_o) begin
            @(negedge clk_i);
            req_valid_i = 1'b0;
            in_flush    = (flush_at >= 0) && (cyc >= flush_at) && (cyc < flush_at + 6);
            flush_i     = in_flush;
            r_ready_i   = ($urandom % 4) != 0;
            w_ready_i   = ($urandom % 4) != 0;
            if ((kill_at >= 0) && (cyc == kill_at)) begin
                kill_i    = 1'b1;
                r_ready_i = 1'b1;
                w_ready_i = 1'b1;
                @(negedge clk_i);
                kill_i = 1'b0;
                #1;
                if (r_busy_o || w_busy_o) report_problem(name, "still busy after kill");
                if (!req_ready_o) report_problem(name, "request not ready after kill");
                exp_r.delete();
                exp_w.delete();
                return;
            end
            #1;
            if (in_flush && (r_valid_o || w_valid_o)) begin
                report_problem(name, "burst valid while flush is high");
            end
            if (coupled && (r_valid_o != w_valid_o)) begin
                report_problem(name, "read and write valids differ in coupled mode");
            end
            act = '{r_addr_o, r_bytes_o, r_beats_o, r_offset_o, r_tailer_o, r_shift_o, 1'b0};
            check_side(name, r_valid_o, act, exp_r);
            act = '{w_addr_o, w_bytes_o, w_beats_o, w_offset_o, w_tailer_o, w_shift_o,
                    w_last_o};
            check_side(name, w_valid_o, act, exp_w);
            cyc++;
            if (cyc > TIMEOUT_CYCLES) abort_on_timeout(name, "the transfer to finish");
        end
    endtask

    // One test of several random transfers of one kind
    task automatic run_test(string name, int kind);
        int          err_before;
        int unsigned len;
        bit          sobi;
        bit          dobi;
        bit          dec;
        err_before = errors;
        repeat (8) begin
            @(negedge clk_i);
            len  = 1 + $urandom % 2048;
            sobi = (kind == 3) ? 1'($urandom) : 1'b0;
            dobi = (kind == 3) ? 1'($urandom) : 1'b0;
            dec  = (kind == 0) ? 1'b1 : (kind == 1 || kind == 5) ? 1'b0 : 1'($urandom);
            req_length_i         = len_t'(len);
            req_src_addr_i       = addr_t'($urandom);
            req_dst_addr_i       = addr_t'($urandom);
            req_src_protocol_i   = sobi ? OBI : AXI;
            req_dst_protocol_i   = dobi ? OBI : AXI;
            req_decouple_rw_i    = dec;
            req_src_reduce_len_i = (kind == 2) || (kind >= 4) || ((kind == 3) && 1'($urandom));
            req_dst_reduce_len_i = (kind == 2) || (kind >= 4) || ((kind == 3) && 1'($urandom));
            // Short bursts keep flush and kill inside the transfer
            req_src_max_llen_i   = (kind >= 4) ? 3'd0 : 3'($urandom);
            req_dst_max_llen_i   = (kind >= 4) ? 3'd1 : 3'($urandom);
            if (kind >= 4) req_length_i = len_t'(len + 512);
            build_model(req_src_addr_i, req_dst_addr_i, req_length_i, sobi, dobi, dec,
                        bound_of(req_src_reduce_len_i, req_src_max_llen_i),
                        bound_of(req_dst_reduce_len_i, req_dst_max_llen_i));
            send_request(name);
            collect_bursts(name, (kind == 4) ? 2 + $urandom % 5 : -1,
                           (kind == 5) ? 3 + $urandom % 10 : -1);
        end
        tests_run++;
        if (errors == err_before) begin
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, errors - err_before);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        void'($urandom(32'hc018edfb));
        rst_n_i              = 1'b0;
        req_valid_i          = 1'b0;
        req_length_i         = '0;
        req_src_addr_i       = '0;
        req_dst_addr_i       = '0;
        req_src_protocol_i   = AXI;
        req_dst_protocol_i   = AXI;
        req_decouple_rw_i    = 1'b0;
        req_src_reduce_len_i = 1'b0;
        req_src_max_llen_i   = '0;
        req_dst_reduce_len_i = 1'b0;
        req_dst_max_llen_i   = '0;
        r_ready_i            = 1'b0;
        w_ready_i            = 1'b0;
        flush_i              = 1'b0;
        kill_i               = 1'b0;
        coupled              = 1'b0;
        errors               = 0;
        tests_run            = 0;
        tests_failed         = 0;
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;

        run_test("decoupled_axi", 0);
        run_test("coupled_axi", 1);
        run_test("reduce_len", 2);
        run_test("format_obi", 3);
        run_test("flush", 4);
        run_test("kill", 5);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/dma_xfer_pkg.sv
hdl/dma_burst_pkg.sv
hdl/dma_side_if.sv
hdl/dma_page_splitter.sv
hdl/dma_side_tracker.sv
hdl/dma_legalizer_ctrl.sv
hdl/dma_legalizer.sv
verif/dma_legalizer_assertions.sv
verif/tb_dma_legalizer.sv

//--- Makefile
TOP := tb_dma_legalizer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
